// ==== src.f ====
+incdir+.
csr_gen_pkg.sv
index_counter_if.sv
index_counter.sv
index_gen_ctrl.sv
request_fifo.sv
csr_index_generator.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSR index generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f src.f --top-module tb_top; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module tb_top;

    localparam int READY_HIGH     = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_HELD_LOW = 2;

    logic                    ap_clk;
    logic                    areset_engine;
    logic                    config_valid;
    logic [`CSR_INDEX_W-1:0] index_start;
    logic [`CSR_INDEX_W-1:0] index_end;
    logic [`CSR_INDEX_W-1:0] stride;
    logic                    step_down;
    logic                    shift_left;
    logic [`CSR_SHIFT_W-1:0] shift_amount;
    logic [`CSR_ROUTE_W-1:0] route;
    logic                    pause;
    logic                    request_ready;
    logic                    request_valid;
    logic [`CSR_INDEX_W-1:0] request_index;
    logic [`CSR_INDEX_W-1:0] request_base;
    logic [`CSR_INDEX_W-1:0] request_offset;
    logic [`CSR_ROUTE_W-1:0] request_route;
    logic                    ready;
    logic                    done;

    csr_gen_pkg::csr_request_t ref_q[$];

    logic [31:0] rnd         = 32'd92;
    int          cycle_count = 0;
    int          deadline    = 2000;

    tb_clock_gen u_clk (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine)
    );

    csr_index_generator u_dut (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .config_valid   (config_valid),
        .index_start    (index_start),
        .index_end      (index_end),
        .stride         (stride),
        .step_down      (step_down),
        .shift_left     (shift_left),
        .shift_amount   (shift_amount),
        .route          (route),
        .pause          (pause),
        .request_ready  (request_ready),
        .request_valid  (request_valid),
        .request_index  (request_index),
        .request_base   (request_base),
        .request_offset (request_offset),
        .request_route  (request_route),
        .ready          (ready),
        .done           (done)
    );

    tb_checker u_chk (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .request_valid  (request_valid),
        .request_index  (request_index),
        .request_base   (request_base),
        .request_offset (request_offset),
        .request_route  (request_route),
        .done           (done)
    );

    // xorshift32
    function automatic logic [31:0] next_rand();
        rnd = rnd ^ (rnd << 13);
        rnd = rnd ^ (rnd >> 17);
        rnd = rnd ^ (rnd << 5);
        return rnd;
    endfunction

    function automatic csr_gen_pkg::index_config_t make_config(
        input logic [31:0] first, input logic [31:0] last, input logic [31:0] step,
        input logic down, input logic left, input logic [4:0] amount, input logic [7:0] tag
    );
        csr_gen_pkg::index_config_t c;
        c.index_start  = first;
        c.index_end    = last;
        c.stride       = step;
        c.step_down    = down;
        c.shift_left   = left;
        c.shift_amount = amount;
        c.route        = tag;
        return c;
    endfunction

    // Expected request list for one run
    function automatic int build_reference(input csr_gen_pkg::index_config_t c);
        logic [`CSR_INDEX_W-1:0]   idx;
        csr_gen_pkg::csr_request_t r;
        ref_q.delete();
        idx = c.index_start;
        while (c.step_down ? (idx > c.index_end) : (idx < c.index_end)) begin
            r.index  = idx;
            r.base   = c.index_start;
            r.offset = c.shift_left ? (idx << c.shift_amount) : (idx >> c.shift_amount);
            r.route  = c.route;
            ref_q.push_back(r);
            idx = c.step_down ? (idx - c.stride) : (idx + c.stride);
        end
        return ref_q.size();
    endfunction

    task automatic run_test(input string name, input csr_gen_pkg::index_config_t c,
                            input int ready_mode, input logic random_pause);
        int          n;
        int          cyc;
        logic [31:0] tmp;
        u_chk.begin_test(name);
        n = build_reference(c);
        foreach (ref_q[i]) begin
            u_chk.push_expected(ref_q[i]);
        end
        deadline = cycle_count + 200 * n + 2000;
        while (!ready) begin
            @(posedge ap_clk);
            #1;
        end
        index_start  = c.index_start;
        index_end    = c.index_end;
        stride       = c.stride;
        step_down    = c.step_down;
        shift_left   = c.shift_left;
        shift_amount = c.shift_amount;
        route        = c.route;
        config_valid = 1'b1;
        @(posedge ap_clk);
        #1;
        config_valid = 1'b0;
        u_chk.arm();
        cyc = 0;
        while (u_chk.armed) begin
            case (ready_mode)
                READY_HIGH:   request_ready = 1'b1;
                READY_RANDOM: request_ready = (next_rand() % 32'd4) != 32'd0;
                default:      request_ready = (cyc >= 100);
            endcase
            tmp   = next_rand();
            pause = random_pause & tmp[0];
            cyc++;
            @(posedge ap_clk);
            #1;
        end
        request_ready = 1'b1;
        pause         = 1'b0;
    endtask

    task automatic random_runs();
        logic [31:0] first;
        logic [31:0] span;
        logic [31:0] step;
        logic [31:0] tmp;
        for (int k = 0; k < 20; k++) begin
            first = 32'd200 + (next_rand() % 32'd4000);
            span  = next_rand() % 32'd130;
            step  = 32'd1 + (next_rand() % 32'd7);
            tmp   = next_rand();
            // Ranges may be empty but never wrap
            run_test($sformatf("random_%0d", k),
                     make_config(first, tmp[0] ? (first - span + 32'd10) : (first + span - 32'd10),
                                 step, tmp[0], tmp[1], tmp[6:2], tmp[15:8]),
                     READY_RANDOM, 1'b0);
        end
    endtask

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < deadline) begin
            @(posedge ap_clk);
        end
        $display("Timeout: the run did not finish within %0d clock cycles", deadline);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        config_valid  = 1'b0;
        index_start   = '0;
        index_end     = '0;
        stride        = '0;
        step_down     = 1'b0;
        shift_left    = 1'b0;
        shift_amount  = '0;
        route         = '0;
        pause         = 1'b0;
        request_ready = 1'b0;

        u_chk.begin_test("reset");
        @(posedge ap_clk);
        #1;
        u_chk.check_level("ready in reset", 1'b0, ready);
        u_chk.check_level("done in reset", 1'b0, done);
        u_chk.check_level("request_valid in reset", 1'b0, request_valid);
        @(negedge areset_engine);
        repeat (2) @(posedge ap_clk);
        #1;
        u_chk.check_level("ready after reset", 1'b1, ready);
        u_chk.check_level("done after reset", 1'b1, done);
        u_chk.report_test();
        request_ready = 1'b1;

        run_test("incr_stride1", make_config(32'd100, 32'd120, 32'd1, 1'b0, 1'b1, 5'd2, 8'h5a),
                 READY_HIGH, 1'b0);
        run_test("decr_stride3", make_config(32'd300, 32'd270, 32'd3, 1'b1, 1'b0, 5'd1, 8'hc3),
                 READY_HIGH, 1'b0);
        run_test("decr_empty", make_config(32'd50, 32'd50, 32'd1, 1'b1, 1'b0, 5'd1, 8'h11),
                 READY_HIGH, 1'b0);
        run_test("backpressure", make_config(32'd1000, 32'd1040, 32'd1, 1'b0, 1'b1, 5'd0, 8'h22),
                 READY_HELD_LOW, 1'b0);
        run_test("pause", make_config(32'd5000, 32'd5060, 32'd2, 1'b0, 1'b0, 5'd3, 8'h33),
                 READY_RANDOM, 1'b1);
        random_runs();

        // Let any stray request surface
        repeat (10) @(posedge ap_clk);
        $display("tests passed: %0d failed: %0d", u_chk.pass_count, u_chk.fail_count);
        if (u_chk.fail_count == 0 && u_chk.error_total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module tb_checker (
    input logic                    ap_clk,
    input logic                    areset_engine,
    input logic                    request_valid,
    input logic [`CSR_INDEX_W-1:0] request_index,
    input logic [`CSR_INDEX_W-1:0] request_base,
    input logic [`CSR_INDEX_W-1:0] request_offset,
    input logic [`CSR_ROUTE_W-1:0] request_route,
    input logic                    done
);

    csr_gen_pkg::csr_request_t exp_q[$];

    string test_name   = "none";
    int    test_errors = 0;
    int    error_total = 0;
    int    pass_count  = 0;
    int    fail_count  = 0;
    logic  armed       = 1'b0;

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic push_expected(input csr_gen_pkg::csr_request_t req);
        exp_q.push_back(req);
    endtask

    // Report the run once done is high and the queue has drained
    task automatic arm();
        armed = 1'b1;
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s ok", test_name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_level(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %b, actual %b", test_name, what, expected, actual);
            test_errors++;
            error_total++;
        end
    endtask

    // ----------------------------------------------------------
    // Request compare on the falling edge
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        csr_gen_pkg::csr_request_t exp_req;
        if (!areset_engine && request_valid) begin
            if (exp_q.size() == 0) begin
                $display("Test %s: request with index %0d arrived when none was expected",
                         test_name, request_index);
                test_errors++;
                error_total++;
            end else begin
                exp_req = exp_q.pop_front();
                if (exp_req.index !== request_index || exp_req.base !== request_base ||
                    exp_req.offset !== request_offset || exp_req.route !== request_route) begin
                    // Fields in order index, base, offset, route
                    $display("ERROR %s: request expected %0d %0d %h %h, actual %0d %0d %h %h",
                             test_name, exp_req.index, exp_req.base, exp_req.offset,
                             exp_req.route, request_index, request_base, request_offset,
                             request_route);
                    test_errors++;
                    error_total++;
                end
            end
        end
        if (armed && done && exp_q.size() == 0) begin
            report_test();
            armed = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic ap_clk,
    output logic areset_engine
);

    // 4 ns period
    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // Reset held over the first two rising edges
    initial begin
        areset_engine = 1'b1;
        repeat (2) @(posedge ap_clk);
        #1 areset_engine = 1'b0;
    end

endmodule

`default_nettype wire

// ==== csr_index_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module csr_index_generator (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    config_valid,
    input  logic [`CSR_INDEX_W-1:0] index_start,
    input  logic [`CSR_INDEX_W-1:0] index_end,
    input  logic [`CSR_INDEX_W-1:0] stride,
    input  logic                    step_down,
    input  logic                    shift_left,
    input  logic [`CSR_SHIFT_W-1:0] shift_amount,
    input  logic [`CSR_ROUTE_W-1:0] route,
    input  logic                    pause,
    input  logic                    request_ready,
    output logic                    request_valid,
    output logic [`CSR_INDEX_W-1:0] request_index,
    output logic [`CSR_INDEX_W-1:0] request_base,
    output logic [`CSR_INDEX_W-1:0] request_offset,
    output logic [`CSR_ROUTE_W-1:0] request_route,
    output logic                    ready,
    output logic                    done
);

    csr_gen_pkg::index_config_t config_in;
    csr_gen_pkg::csr_request_t  push_data;
    csr_gen_pkg::csr_request_t  fifo_out;

    logic push;
    logic prog_full;

    index_counter_if cnt_if ();

    // ----------------------------------------------------------
    // Port packing
    // ----------------------------------------------------------
    always_comb begin
        config_in.index_start  = index_start;
        config_in.index_end    = index_end;
        config_in.stride       = stride;
        config_in.step_down    = step_down;
        config_in.shift_left   = shift_left;
        config_in.shift_amount = shift_amount;
        config_in.route        = route;
    end

    assign request_index  = fifo_out.index;
    assign request_base   = fifo_out.base;
    assign request_offset = fifo_out.offset;
    assign request_route  = fifo_out.route;

    index_gen_ctrl u_ctrl (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .config_valid  (config_valid),
        .config_in     (config_in),
        .pause         (pause),
        .prog_full     (prog_full),
        .cnt           (cnt_if.ctrl),
        .push          (push),
        .push_data     (push_data),
        .ready         (ready),
        .done          (done)
    );

    index_counter u_counter (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .cnt           (cnt_if.counter)
    );

    // Consumer pops with a plain read-enable level
    request_fifo u_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push          (push),
        .push_data     (push_data),
        .pop           (request_ready),
        .out_data      (fifo_out),
        .out_valid     (request_valid),
        .prog_full     (prog_full)
    );

endmodule

`default_nettype wire

// ==== request_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module request_fifo (
    input  logic                      ap_clk,
    input  logic                      areset_engine,
    input  logic                      push,
    input  csr_gen_pkg::csr_request_t push_data,
    input  logic                      pop,
    output csr_gen_pkg::csr_request_t out_data,
    output logic                      out_valid,
    output logic                      prog_full
);

    localparam logic [`CSR_FIFO_AW:0] DEPTH_CNT  = `CSR_FIFO_DEPTH;
    localparam logic [`CSR_FIFO_AW:0] THRESH_CNT = `CSR_FIFO_PROG_THRESH;

    csr_gen_pkg::csr_request_t mem [`CSR_FIFO_DEPTH];

    logic [`CSR_FIFO_AW-1:0] wr_ptr;
    logic [`CSR_FIFO_AW-1:0] rd_ptr;
    logic [`CSR_FIFO_AW:0]   count;
    logic                    full;
    logic                    empty;
    logic                    do_push;
    logic                    do_pop;

    assign full    = (count == DEPTH_CNT);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Pointers, occupancy and flags
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
            prog_full <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            out_valid <= do_pop;
            prog_full <= (count >= THRESH_CNT);
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            out_data <= mem[rd_ptr];
        end
    end

    // prog_full lag must never let the writer overrun the buffer
    a_no_push_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        push |-> !full
    );

endmodule

`default_nettype wire

// ==== index_gen_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module index_gen_ctrl (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    input  logic                       config_valid,
    input  csr_gen_pkg::index_config_t config_in,
    input  logic                       pause,
    input  logic                       prog_full,
    index_counter_if.ctrl              cnt,
    output logic                       push,
    output csr_gen_pkg::csr_request_t  push_data,
    output logic                       ready,
    output logic                       done
);

    csr_gen_pkg::gen_state_e    state;
    csr_gen_pkg::gen_state_e    next_state;
    csr_gen_pkg::index_config_t cfg;
    csr_gen_pkg::csr_request_t  req;

    logic accept;
    logic stall;
    logic in_range;
    logic advance;

    assign accept = ready && config_valid;
    assign stall  = prog_full || pause;

    // Direction aware end test
    assign in_range = cfg.step_down ? (cnt.count > cfg.index_end)
                                    : (cnt.count < cfg.index_end);

    assign advance = (state == csr_gen_pkg::BUSY) && in_range && !stall;

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------
    always_comb begin
        next_state = state;
        unique case (state)
            csr_gen_pkg::IDLE: begin
                if (accept) begin
                    next_state = csr_gen_pkg::SETUP;
                end
            end
            csr_gen_pkg::SETUP: begin
                next_state = csr_gen_pkg::BUSY;
            end
            csr_gen_pkg::BUSY: begin
                if (!in_range) begin
                    next_state = csr_gen_pkg::DONE;
                end else if (stall) begin
                    next_state = csr_gen_pkg::PAUSE;
                end
            end
            csr_gen_pkg::PAUSE: begin
                if (!stall) begin
                    next_state = csr_gen_pkg::BUSY;
                end
            end
            default: begin
                next_state = csr_gen_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= csr_gen_pkg::IDLE;
            ready <= 1'b0;
            done  <= 1'b0;
            push  <= 1'b0;
        end else begin
            state <= next_state;
            ready <= (next_state == csr_gen_pkg::IDLE);
            done  <= (next_state == csr_gen_pkg::IDLE);
            push  <= advance;
        end
    end

    // Run configuration held for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            cfg <= config_in;
        end
    end

    // ----------------------------------------------------------
    // Counter control and request formation
    // ----------------------------------------------------------
    assign cnt.enable     = (state == csr_gen_pkg::SETUP) || advance;
    assign cnt.load       = (state == csr_gen_pkg::SETUP);
    assign cnt.step_down  = cfg.step_down;
    assign cnt.load_value = cfg.index_start;
    assign cnt.stride     = cfg.stride;

    always_comb begin
        req.index  = cnt.count;
        req.base   = cfg.index_start;
        req.offset = cfg.shift_left ? (cnt.count << cfg.shift_amount)
                                    : (cnt.count >> cfg.shift_amount);
        req.route  = cfg.route;
    end

    always_ff @(posedge ap_clk) begin
        if (advance) begin
            push_data <= req;
        end
    end

    a_push_in_busy : assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        push |-> state == csr_gen_pkg::BUSY
    );

    a_ready_in_idle : assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        ready |-> state == csr_gen_pkg::IDLE
    );

endmodule

`default_nettype wire

// ==== index_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

module index_counter (
    input logic              ap_clk,
    input logic              areset_engine,
    index_counter_if.counter cnt
);

    logic [`CSR_INDEX_W-1:0] count_next;

    // Load wins over a stride step
    always_comb begin
        if (cnt.load) begin
            count_next = cnt.load_value;
        end else if (cnt.step_down) begin
            count_next = cnt.count - cnt.stride;
        end else begin
            count_next = cnt.count + cnt.stride;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            cnt.count <= '0;
        end else if (cnt.enable) begin
            cnt.count <= count_next;
        end
    end

    // Index must hold while the controller has the counter stopped
    a_hold_when_disabled : assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        !cnt.enable |=> $stable(cnt.count)
    );

endmodule

`default_nettype wire

// ==== index_counter_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csr_gen_params.svh"

interface index_counter_if;
    logic                    enable;
    logic                    load;
    logic                    step_down;
    logic [`CSR_INDEX_W-1:0] load_value;
    logic [`CSR_INDEX_W-1:0] stride;
    logic [`CSR_INDEX_W-1:0] count;

    // Controller side
    modport ctrl (
        output enable, load, step_down, load_value, stride,
        input  count
    );

    // Stride counter side
    modport counter (
        input  enable, load, step_down, load_value, stride,
        output count
    );
endinterface

`default_nettype wire

// ==== csr_gen_pkg.sv ====
`default_nettype none

`include "csr_gen_params.svh"

package csr_gen_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        BUSY,
        PAUSE,
        DONE
    } gen_state_e;

    // One run of the generator
    typedef struct packed {
        logic [`CSR_INDEX_W-1:0] index_start;
        logic [`CSR_INDEX_W-1:0] index_end;
        logic [`CSR_INDEX_W-1:0] stride;
        logic                    step_down;
        logic                    shift_left;
        logic [`CSR_SHIFT_W-1:0] shift_amount;
        logic [`CSR_ROUTE_W-1:0] route;
    } index_config_t;

    // Memory request as queued in the FIFO
    typedef struct packed {
        logic [`CSR_INDEX_W-1:0] index;
        logic [`CSR_INDEX_W-1:0] base;
        logic [`CSR_INDEX_W-1:0] offset;
        logic [`CSR_ROUTE_W-1:0] route;
    } csr_request_t;

endpackage

`default_nettype wire

// ==== csr_gen_params.svh ====
`ifndef CSR_GEN_PARAMS_SVH
`define CSR_GEN_PARAMS_SVH

// Request field widths
`define CSR_INDEX_W 32
`define CSR_SHIFT_W 5
`define CSR_ROUTE_W 8

// Request FIFO sizing
`define CSR_FIFO_DEPTH 16
`define CSR_FIFO_AW 4

// Occupancy that raises prog_full
`define CSR_FIFO_PROG_THRESH 8

`endif
